/* src/bf_pkg.sv */
package bf_pkg;

	localparam int NODE_W   = 5;
	localparam int WEIGHT_W = 4;
	localparam int DIST_W   = 10;
	localparam int LANES    = 4; // sort network is built for four
	localparam int NODES    = 1 << NODE_W;

	typedef logic [NODE_W-1:0]   node_t;
	typedef logic [WEIGHT_W-1:0] weight_t;
	typedef logic [DIST_W-1:0]   dist_t;

	// top bit set means unreachable
	localparam dist_t DIST_INF = {1'b1, {(DIST_W-1){1'b0}}};

	// edge word: {weight, tail, head}, all zero ends the list
	localparam int EDGE_W = WEIGHT_W + 2 * NODE_W;
	typedef logic [EDGE_W-1:0] edge_t;

	// register file word: {dist, pred}
	typedef logic [DIST_W+NODE_W-1:0] entry_t;

	// sort lane: {update, edge, tail dist}
	localparam int SORT_W = 1 + EDGE_W + DIST_W;
	typedef logic [SORT_W-1:0] sort_t;

	// relax lane: {update, edge, tail dist, head dist}
	localparam int WORK_W = SORT_W + DIST_W;
	typedef logic [WORK_W-1:0] work_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_CLEAR,
		ST_RELAX,
		ST_READY,
		ST_READ,
		ST_TRACE
	} ctrl_state_t;

	function automatic node_t edge_head(input edge_t e);
		return e[NODE_W-1:0];
	endfunction

	function automatic node_t edge_tail(input edge_t e);
		return e[2*NODE_W-1:NODE_W];
	endfunction

	function automatic weight_t edge_weight(input edge_t e);
		return e[EDGE_W-1 -: WEIGHT_W];
	endfunction

endpackage

/* src/edge_store.sv */
`timescale 1ns/1ps

module edge_store #(
	parameter int EDGE_WORDS = 32
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           clear,
	input  logic           enable,
	input  logic           wr,
	input  bf_pkg::node_t  wr_addr,
	input  bf_pkg::edge_t  wr_data,
	output bf_pkg::edge_t  edges [bf_pkg::LANES],
	output logic           wrap
);

	localparam int PTR_W = $clog2(EDGE_WORDS);

	bf_pkg::edge_t  mem [EDGE_WORDS];
	logic [PTR_W-1:0] ptr;
	logic [PTR_W:0]   nxt; // one extra bit to see the end of memory

	always_ff @(posedge clk) begin
		if (wr && wr_addr < EDGE_WORDS)
			mem[wr_addr[PTR_W-1:0]] <= wr_data;
	end

	assign nxt  = {1'b0, ptr} + (PTR_W+1)'(bf_pkg::LANES);
	// next group starts with the terminator, or memory runs out
	assign wrap = enable && (nxt >= EDGE_WORDS || mem[nxt[PTR_W-1:0]] == '0);

	always_ff @(posedge clk) begin
		if (rst || clear)
			ptr <= '0;
		else if (wrap)
			ptr <= '0;
		else if (enable)
			ptr <= nxt[PTR_W-1:0];
	end

	always_comb begin
		for (int i = 0; i < bf_pkg::LANES; i++)
			edges[i] = mem[ptr + PTR_W'(i)];
	end

endmodule

/* src/dist_regfile.sv */
`timescale 1ns/1ps

module dist_regfile (
	input  logic           clk,
	input  logic           rst,
	input  logic           init,
	input  bf_pkg::node_t  source_node,
	input  bf_pkg::node_t  rd_addr [2*bf_pkg::LANES],
	output bf_pkg::entry_t rd_entry [2*bf_pkg::LANES],
	input  logic [bf_pkg::LANES-1:0] wr_en,
	input  bf_pkg::node_t  wr_addr [bf_pkg::LANES],
	input  bf_pkg::entry_t wr_entry [bf_pkg::LANES]
);

	bf_pkg::entry_t regs [bf_pkg::NODES];

	always_ff @(posedge clk) begin
		if (init) begin
			for (int n = 0; n < bf_pkg::NODES; n++) begin
				if (bf_pkg::node_t'(n) == source_node)
					regs[n] <= '0; // source: dist 0
				else
					regs[n] <= {bf_pkg::DIST_INF, bf_pkg::node_t'(0)};
			end
		end else if (!rst) begin
			// lane addresses are distinct after the sorter
			for (int l = 0; l < bf_pkg::LANES; l++) begin
				if (wr_en[l])
					regs[wr_addr[l]] <= wr_entry[l];
			end
		end
	end

	always_comb begin
		for (int p = 0; p < 2 * bf_pkg::LANES; p++)
			rd_entry[p] = regs[rd_addr[p]];
	end

endmodule

/* src/edge_sorter.sv */
`timescale 1ns/1ps

module edge_sorter (
	input  bf_pkg::sort_t lanes_in  [bf_pkg::LANES],
	output bf_pkg::sort_t lanes_out [bf_pkg::LANES]
);

	bf_pkg::sort_t s1 [bf_pkg::LANES];
	bf_pkg::sort_t s2 [bf_pkg::LANES];

	// invalid lanes sort above every valid one
	function automatic logic [bf_pkg::NODE_W:0] sort_key(input bf_pkg::sort_t x);
		return {~x[bf_pkg::SORT_W-1], bf_pkg::edge_head(x[bf_pkg::SORT_W-2 -: bf_pkg::EDGE_W])};
	endfunction

	// tail distance plus weight
	function automatic logic [bf_pkg::DIST_W:0] relax_sum(input bf_pkg::sort_t x);
		bf_pkg::edge_t e;
		e = x[bf_pkg::SORT_W-2 -: bf_pkg::EDGE_W];
		return x[bf_pkg::DIST_W-1:0] + bf_pkg::edge_weight(e);
	endfunction

	// returns {first, second}
	function automatic logic [2*bf_pkg::SORT_W-1:0] cmp_ex(
		input bf_pkg::sort_t a,
		input bf_pkg::sort_t b,
		input logic          asc
	);
		bf_pkg::sort_t x;
		bf_pkg::sort_t y;
		logic          swap;
		x = a;
		y = b;
		if (sort_key(x) == sort_key(y) && x[bf_pkg::SORT_W-1]) begin
			// same head, keep the better path only
			if (relax_sum(x) <= relax_sum(y))
				y[bf_pkg::SORT_W-1] = 1'b0;
			else
				x[bf_pkg::SORT_W-1] = 1'b0;
		end
		swap = asc ? (sort_key(x) > sort_key(y)) : (sort_key(x) < sort_key(y));
		return swap ? {y, x} : {x, y};
	endfunction

	always_comb begin
		{s1[0], s1[1]} = cmp_ex(lanes_in[0], lanes_in[1], 1'b1);
		{s1[2], s1[3]} = cmp_ex(lanes_in[2], lanes_in[3], 1'b0); // bitonic half
		{s2[0], s2[2]} = cmp_ex(s1[0], s1[2], 1'b1);
		{s2[1], s2[3]} = cmp_ex(s1[1], s1[3], 1'b1);
		{lanes_out[0], lanes_out[1]} = cmp_ex(s2[0], s2[1], 1'b1);
		{lanes_out[2], lanes_out[3]} = cmp_ex(s2[2], s2[3], 1'b1);
	end

endmodule

/* src/dist_forward.sv */
`timescale 1ns/1ps

module dist_forward (
	input  bf_pkg::work_t lanes_in  [bf_pkg::LANES],
	input  logic [bf_pkg::LANES-1:0] fwd_valid,
	input  bf_pkg::node_t fwd_node  [bf_pkg::LANES],
	input  bf_pkg::dist_t fwd_dist  [bf_pkg::LANES],
	output bf_pkg::work_t lanes_out [bf_pkg::LANES]
);

	logic          upd;
	bf_pkg::edge_t e;
	bf_pkg::dist_t td;
	bf_pkg::dist_t hd;

	always_comb begin
		for (int j = 0; j < bf_pkg::LANES; j++) begin
			{upd, e, td, hd} = lanes_in[j];
			for (int i = 0; i < bf_pkg::LANES; i++) begin
				if (fwd_valid[i]) begin
					if (fwd_node[i] == bf_pkg::edge_head(e))
						hd = fwd_dist[i];
					if (fwd_node[i] == bf_pkg::edge_tail(e))
						td = fwd_dist[i]; // stale tail from the read stage
				end
			end
			lanes_out[j] = {upd, e, td, hd};
		end
	end

endmodule

/* src/bf_pipeline.sv */
`timescale 1ns/1ps

module bf_pipeline #(
	parameter int EDGE_WORDS = 32
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           clear,
	input  logic           enable,
	input  bf_pkg::node_t  source_node,
	input  logic           edge_wr,
	input  bf_pkg::node_t  edge_wr_addr,
	input  bf_pkg::edge_t  edge_wr_data,
	input  logic           trace_sel,
	input  bf_pkg::node_t  trace_addr,
	output logic           converged,
	output bf_pkg::entry_t trace_entry
);

	localparam int L     = bf_pkg::LANES;
	localparam int CNT_W = $clog2(EDGE_WORDS) + 2;

	bf_pkg::edge_t  edges [L];
	logic           wrap;
	bf_pkg::node_t  rd_addr [2*L];
	bf_pkg::entry_t rd_entry [2*L];
	bf_pkg::sort_t  rd_lane [L];
	bf_pkg::sort_t  s1 [L];
	bf_pkg::sort_t  sorted [L];
	bf_pkg::sort_t  s2 [L];
	bf_pkg::work_t  mem_lane [L];
	bf_pkg::work_t  mem_fwd [L];
	bf_pkg::work_t  s3 [L];
	bf_pkg::work_t  cmp_lane [L];
	bf_pkg::work_t  cmp_out [L];
	bf_pkg::work_t  s4 [L];
	logic [L-1:0]   wr_en;
	bf_pkg::node_t  wr_addr [L];
	bf_pkg::dist_t  wr_dist [L];
	bf_pkg::entry_t wr_entry [L];
	logic           any_upd;
	logic [CNT_W-1:0] gcnt, plen, quiet;
	logic           armed;

	edge_store #(.EDGE_WORDS(EDGE_WORDS)) i_edge_store (
		.clk(clk), .rst(rst), .clear(clear), .enable(enable),
		.wr(edge_wr), .wr_addr(edge_wr_addr), .wr_data(edge_wr_data),
		.edges(edges), .wrap(wrap)
	);

	dist_regfile i_dist_regfile (
		.clk(clk), .rst(rst), .init(clear), .source_node(source_node),
		.rd_addr(rd_addr), .rd_entry(rd_entry),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_entry(wr_entry)
	);

	// read stage: tail distances, lanes past the terminator are dropped
	always_comb begin
		logic ended;
		ended = 1'b0;
		for (int i = 0; i < L; i++) begin
			if (edges[i] == '0)
				ended = 1'b1;
			rd_addr[i]     = bf_pkg::edge_tail(edges[i]);
			rd_addr[L + i] = bf_pkg::edge_head(s2[i][bf_pkg::SORT_W-2 -: bf_pkg::EDGE_W]);
			rd_lane[i]     = {~ended, edges[i], rd_entry[i][bf_pkg::DIST_W+bf_pkg::NODE_W-1 -: bf_pkg::DIST_W]};
		end
		if (trace_sel)
			rd_addr[0] = trace_addr; // path walk borrows lane 0
	end

	assign trace_entry = rd_entry[0];

	edge_sorter i_edge_sorter (.lanes_in(s1), .lanes_out(sorted));

	// head distances read on the sorted order
	always_comb begin
		for (int i = 0; i < L; i++)
			mem_lane[i] = {s2[i], rd_entry[L+i][bf_pkg::DIST_W+bf_pkg::NODE_W-1 -: bf_pkg::DIST_W]};
	end

	dist_forward i_fwd_mem (
		.lanes_in(mem_lane), .fwd_valid(wr_en), .fwd_node(wr_addr),
		.fwd_dist(wr_dist), .lanes_out(mem_fwd)
	);

	dist_forward i_fwd_cmp (
		.lanes_in(s3), .fwd_valid(wr_en), .fwd_node(wr_addr),
		.fwd_dist(wr_dist), .lanes_out(cmp_lane)
	);

	// relaxation compare
	always_comb begin
		logic          upd;
		bf_pkg::edge_t e;
		bf_pkg::dist_t td, hd, sum;
		logic          hit;
		for (int i = 0; i < L; i++) begin
			{upd, e, td, hd} = cmp_lane[i];
			sum = td + bf_pkg::edge_weight(e); // cannot overflow when td is finite
			hit = upd && !td[bf_pkg::DIST_W-1] && sum < hd;
			cmp_out[i] = {hit, e, td, hit ? sum : hd};
		end
	end

	always_ff @(posedge clk) begin
		if (rst || clear) begin
			for (int i = 0; i < L; i++) begin
				s1[i] <= '0;
				s2[i] <= '0;
				s3[i] <= '0;
				s4[i] <= '0;
			end
		end else if (enable) begin
			s1 <= rd_lane;
			s2 <= sorted;
			s3 <= mem_fwd;
			s4 <= cmp_out;
		end
	end

	// write-back
	always_comb begin
		for (int i = 0; i < L; i++) begin
			wr_en[i]    = enable && s4[i][bf_pkg::WORK_W-1];
			wr_addr[i]  = bf_pkg::edge_head(s4[i][bf_pkg::WORK_W-2 -: bf_pkg::EDGE_W]);
			wr_dist[i]  = s4[i][bf_pkg::DIST_W-1:0];
			wr_entry[i] = {wr_dist[i], bf_pkg::edge_tail(s4[i][bf_pkg::WORK_W-2 -: bf_pkg::EDGE_W])};
		end
	end

	assign any_upd = |wr_en;

	// early stop: quiet for a whole pass plus the pipeline drain
	always_ff @(posedge clk) begin
		if (rst || clear) begin
			gcnt      <= '0;
			plen      <= '0;
			quiet     <= '0;
			armed     <= 1'b0;
			converged <= 1'b0;
		end else if (enable) begin
			if (wrap) begin
				plen  <= gcnt + 1'b1; // groups per pass
				gcnt  <= '0;
				armed <= 1'b1;
			end else begin
				gcnt <= gcnt + 1'b1;
			end
			if (any_upd)
				quiet <= '0;
			else if (quiet != '1)
				quiet <= quiet + 1'b1;
			if (armed && quiet >= plen + CNT_W'(L + 1))
				converged <= 1'b1;
		end
	end

endmodule

/* src/bf_control.sv */
`timescale 1ns/1ps

module bf_control (
	input  logic           clk,
	input  logic           rst,
	input  logic           start,
	input  bf_pkg::node_t  source_node,
	input  logic           query,
	input  bf_pkg::node_t  dest_node,
	input  logic           converged,
	input  bf_pkg::entry_t trace_entry,
	output logic           clear,
	output logic           enable,
	output logic           trace_sel,
	output bf_pkg::node_t  trace_addr,
	output logic           busy,
	output logic           done,
	output bf_pkg::dist_t  dist_out,
	output logic           path_valid,
	output bf_pkg::node_t  path_node,
	output logic           path_last
);

	bf_pkg::ctrl_state_t state;
	bf_pkg::node_t       src;
	bf_pkg::node_t       cur;
	bf_pkg::node_t       beats; // loop guard
	bf_pkg::dist_t       cur_dist;
	bf_pkg::node_t       cur_pred;
	logic                last;

	assign clear     = state == bf_pkg::ST_CLEAR;
	assign enable    = state == bf_pkg::ST_RELAX;
	assign busy      = clear || enable || state == bf_pkg::ST_READ || state == bf_pkg::ST_TRACE;
	assign done      = state == bf_pkg::ST_READY || state == bf_pkg::ST_READ
		|| state == bf_pkg::ST_TRACE;
	assign trace_sel = done;
	assign trace_addr = (state == bf_pkg::ST_READY) ? dest_node : cur;

	assign {cur_dist, cur_pred} = trace_entry;
	// stop on source, unreachable node, or too many steps
	assign last = cur == src || cur_dist[bf_pkg::DIST_W-1] || beats == '1;

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= bf_pkg::ST_IDLE;
			path_valid <= 1'b0;
		end else begin
			path_valid <= 1'b0;
			case (state)
				bf_pkg::ST_IDLE, bf_pkg::ST_READY: begin
					if (start) begin
						state <= bf_pkg::ST_CLEAR;
						src   <= source_node;
					end else if (state == bf_pkg::ST_READY && query) begin
						state    <= bf_pkg::ST_READ;
						cur      <= dest_node;
						dist_out <= cur_dist; // entry of dest_node
						beats    <= '0;
					end
				end
				bf_pkg::ST_CLEAR: state <= bf_pkg::ST_RELAX;
				bf_pkg::ST_RELAX: begin
					if (converged)
						state <= bf_pkg::ST_READY;
				end
				bf_pkg::ST_READ, bf_pkg::ST_TRACE: begin
					path_valid <= 1'b1;
					path_node  <= cur;
					path_last  <= last;
					cur        <= cur_pred;
					beats      <= beats + 1'b1;
					state      <= last ? bf_pkg::ST_READY : bf_pkg::ST_TRACE;
				end
				default: state <= bf_pkg::ST_IDLE;
			endcase
		end
	end

endmodule

/* src/bellman_ford.sv */
`timescale 1ns/1ps

module bellman_ford #(
	parameter int EDGE_WORDS = 32 // multiple of the lane count
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           edge_wr,
	input  bf_pkg::node_t  edge_wr_addr,
	input  bf_pkg::edge_t  edge_wr_data,
	input  logic           start,
	input  bf_pkg::node_t  source_node,
	input  logic           query,
	input  bf_pkg::node_t  dest_node,
	output logic           busy,
	output logic           done,
	output bf_pkg::dist_t  dist_out,
	output logic           path_valid,
	output logic           path_last,
	output bf_pkg::node_t  path_node
);

	logic           clear;
	logic           enable;
	logic           trace_sel;
	bf_pkg::node_t  trace_addr;
	logic           converged;
	bf_pkg::entry_t trace_entry;

	bf_control i_bf_control (
		.clk(clk), .rst(rst), .start(start), .source_node(source_node),
		.query(query), .dest_node(dest_node),
		.converged(converged), .trace_entry(trace_entry),
		.clear(clear), .enable(enable), .trace_sel(trace_sel), .trace_addr(trace_addr),
		.busy(busy), .done(done), .dist_out(dist_out),
		.path_valid(path_valid), .path_node(path_node), .path_last(path_last)
	);

	// pipeline seeds the register file from the live source input in the clear cycle
	bf_pipeline #(.EDGE_WORDS(EDGE_WORDS)) i_bf_pipeline (
		.clk(clk), .rst(rst), .clear(clear), .enable(enable),
		.source_node(source_node),
		.edge_wr(edge_wr), .edge_wr_addr(edge_wr_addr), .edge_wr_data(edge_wr_data),
		.trace_sel(trace_sel), .trace_addr(trace_addr),
		.converged(converged), .trace_entry(trace_entry)
	);

endmodule

/* sim/bf_ref_model.svh */
`ifndef BF_REF_MODEL_SVH
`define BF_REF_MODEL_SVH

// repeated relaxation over the loaded list until a sweep changes nothing
function automatic void compute_distances(input int src);
	bit changed;
	int cand;
	for (int n = 0; n < bf_pkg::NODES; n++)
		ref_dist[n] = (n == src) ? 0 : UNREACHABLE;
	changed = 1'b1;
	while (changed) begin
		changed = 1'b0;
		for (int k = 0; k < n_edges; k++) begin
			if (ref_dist[e_tail[k]] != UNREACHABLE) begin
				cand = ref_dist[e_tail[k]] + e_weight[k];
				if (cand < ref_dist[e_head[k]]) begin
					ref_dist[e_head[k]] = cand;
					changed = 1'b1;
				end
			end
		end
	end
endfunction

// lightest loaded edge tail -> head, -1 if there is none
function automatic int min_edge_weight(input int tail, input int head);
	int best;
	best = -1;
	for (int k = 0; k < n_edges; k++) begin
		if (e_tail[k] == tail && e_head[k] == head && (best < 0 || e_weight[k] < best))
			best = e_weight[k];
	end
	return best;
endfunction

// path_q holds the beats, destination first
task automatic check_path(input int dest, input int src);
	int sum;
	int w;
	if (path_q.size() == 0) begin
		$display("no path beat arrived for destination %0d at %0t", dest, $time);
		errors++;
		return;
	end
	if (path_q[0] != dest) begin
		$display("** Error at %0t: path_node expected %0d, got %0d", $time, dest, path_q[0]);
		errors++;
	end
	if (ref_dist[dest] == UNREACHABLE) begin
		if (path_q.size() != 1) begin
			$display("unreachable node %0d gave %0d path beats instead of one",
				dest, path_q.size());
			errors++;
		end
		return;
	end
	if (path_q[$] != src) begin
		$display("** Error at %0t: path_node expected %0d, got %0d", $time, src, path_q[$]);
		errors++;
	end
	sum = 0;
	for (int i = 0; i + 1 < path_q.size(); i++) begin
		w = min_edge_weight(path_q[i+1], path_q[i]);
		if (w < 0) begin
			$display("path step %0d -> %0d follows no loaded edge", path_q[i+1], path_q[i]);
			errors++;
			return;
		end
		sum += w;
	end
	if (sum != ref_dist[dest]) begin
		$display("** Error at %0t: path weight sum expected %0d, got %0d",
			$time, ref_dist[dest], sum);
		errors++;
	end
endtask

`endif

/* sim/bf_tb.sv */
`timescale 1ns/1ps

module bf_tb;

	localparam int EDGE_WORDS   = 32;
	localparam int CLK_PERIOD   = 4;
	localparam int TRIALS       = 8;
	localparam int UNREACHABLE  = 512;
	localparam int RUN_LIMIT    = EDGE_WORDS * 100;
	localparam int PATH_LIMIT   = 2 * bf_pkg::NODES + 4;
	localparam int WATCH_CYCLES = TRIALS * EDGE_WORDS * 200;

	logic          clk;
	logic          rst;
	logic          edge_wr;
	bf_pkg::node_t edge_wr_addr;
	bf_pkg::edge_t edge_wr_data;
	logic          start;
	bf_pkg::node_t source_node;
	logic          query;
	bf_pkg::node_t dest_node;
	logic          busy;
	logic          done;
	bf_pkg::dist_t dist_out;
	logic          path_valid;
	logic          path_last;
	bf_pkg::node_t path_node;

	int n_edges;
	int e_tail   [EDGE_WORDS];
	int e_head   [EDGE_WORDS];
	int e_weight [EDGE_WORDS];
	int ref_dist [bf_pkg::NODES];
	int path_q   [$];
	int errors;
	int queries;

	`include "bf_ref_model.svh"

	bellman_ford #(.EDGE_WORDS(EDGE_WORDS)) i_bellman_ford (
		.clk(clk), .rst(rst),
		.edge_wr(edge_wr), .edge_wr_addr(edge_wr_addr), .edge_wr_data(edge_wr_data),
		.start(start), .source_node(source_node), .query(query), .dest_node(dest_node),
		.busy(busy), .done(done), .dist_out(dist_out),
		.path_valid(path_valid), .path_last(path_last), .path_node(path_node)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCH_CYCLES * CLK_PERIOD);
		$display("timeout: run did not finish within %0d cycles", WATCH_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

	task automatic expect_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("** Error at %0t: %s expected %0b, got %0b", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic build_graph(output int src);
		int span;
		span    = 4 + $urandom % 29; // nodes in use this trial
		n_edges = 4 + $urandom % 25;
		for (int i = 0; i < n_edges; i++) begin
			e_tail[i]   = $urandom % span;
			e_head[i]   = $urandom % span;
			e_weight[i] = 1 + $urandom % 15;
		end
		src = $urandom % span;
	endtask

	task automatic load_edges();
		for (int a = 0; a < EDGE_WORDS; a++) begin
			@(negedge clk);
			edge_wr      = 1'b1;
			edge_wr_addr = bf_pkg::node_t'(a);
			if (a < n_edges)
				edge_wr_data = {bf_pkg::weight_t'(e_weight[a]), bf_pkg::node_t'(e_tail[a]),
					bf_pkg::node_t'(e_head[a])};
			else
				edge_wr_data = '0; // terminator, then padding
		end
		@(negedge clk);
		edge_wr = 1'b0;
	endtask

	task automatic run_engine(input int src, output bit ok);
		int cycles;
		@(negedge clk);
		start       = 1'b1;
		source_node = bf_pkg::node_t'(src);
		@(negedge clk);
		start = 1'b0;
		expect_bit("busy", 1'b1, busy);
		expect_bit("done", 1'b0, done); // previous result is gone
		cycles = 0;
		while (!done && cycles < RUN_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		ok = done;
		if (!ok) begin
			$display("relaxation from source %0d never reached done at %0t", src, $time);
			errors++;
		end else begin
			expect_bit("busy", 1'b0, busy);
		end
	endtask

	task automatic query_node(input int dest, input int src);
		int  cycles;
		bit  got_last;
		@(negedge clk);
		query     = 1'b1;
		dest_node = bf_pkg::node_t'(dest);
		@(negedge clk);
		query = 1'b0;
		queries++;
		if (int'(dist_out) != ref_dist[dest]) begin
			$display("** Error at %0t: dist_out for node %0d expected %0d, got %0d",
				$time, dest, ref_dist[dest], dist_out);
			errors++;
		end
		path_q.delete();
		got_last = 1'b0;
		cycles   = 0;
		while (!got_last && cycles < PATH_LIMIT) begin
			if (path_valid) begin
				path_q.push_back(int'(path_node));
				got_last = path_last;
			end
			if (!got_last) begin
				@(negedge clk);
				cycles++;
			end
		end
		if (!got_last) begin
			$display("path stream for node %0d never ended with path_last", dest);
			errors++;
		end
		check_path(dest, src);
	endtask

	initial begin
		int  src;
		bit  ok;
		errors       = 0;
		queries      = 0;
		void'($urandom(32'he774));
		rst          = 1'b1;
		edge_wr      = 1'b0;
		edge_wr_addr = '0;
		edge_wr_data = '0;
		start        = 1'b0;
		source_node  = '0;
		query        = 1'b0;
		dest_node    = '0;
		repeat (8) @(negedge clk);
		rst = 1'b0;

		// idle after reset
		repeat (4) begin
			@(negedge clk);
			expect_bit("busy", 1'b0, busy);
			expect_bit("done", 1'b0, done);
			expect_bit("path_valid", 1'b0, path_valid);
		end

		for (int t = 0; t < TRIALS; t++) begin
			build_graph(src);
			load_edges();
			compute_distances(src);
			run_engine(src, ok);
			if (ok) begin
				for (int n = 0; n < bf_pkg::NODES; n++)
					query_node(n, src);
			end
		end

		$display("trials %0d, queries %0d, errors %0d", TRIALS, queries, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* bellman_ford.f */
+incdir+sim
src/bf_pkg.sv
src/edge_store.sv
src/dist_regfile.sv
src/edge_sorter.sv
src/dist_forward.sv
src/bf_pipeline.sv
src/bf_control.sv
src/bellman_ford.sv
sim/bf_tb.sv

/* Bender.yml */
package:
  name: bellman_ford

sources:
  - src/bf_pkg.sv
  - src/edge_store.sv
  - src/dist_regfile.sv
  - src/edge_sorter.sv
  - src/dist_forward.sv
  - src/bf_pipeline.sv
  - src/bf_control.sv
  - src/bellman_ford.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/bf_tb.sv
